// ==== common/aes_pkg.sv ====
/*
 * AES ShiftRows shared definitions
 * Byte, row and state vector types for the streaming ShiftRows path,
 * the row index type and the fill and drain states of the row buffer.
 * A row carries byte 0 in its low 8 bits. The state holds row r at
 * bit offset 32*r.
 */

package aes_pkg;

  // rows per state, also bytes per row
  localparam int NUM_ROWS = 4;

  // one state byte
  typedef logic [7:0] byte_t;

  // four bytes of one state row
  typedef logic [NUM_ROWS*8-1:0] row_t;

  // full 16-byte AES state
  typedef logic [NUM_ROWS*NUM_ROWS*8-1:0] state_t;

  // row index, 0 to 3
  typedef logic [1:0] row_idx_t;

  // row buffer fill and drain states
  typedef enum logic [1:0] {
    FILLING  = 2'd0,
    FULL     = 2'd1,
    DRAINING = 2'd2
  } buf_state_t;

endpackage

// ==== shift_rows/row_buffer.sv ====
/*
 * Row buffer
 * Collects the four rows of one AES state while wr_en is high and
 * raises full once all four are held. While full is high and wr_en
 * is low it releases one row per cycle, in order, on a registered
 * row_data output with a one-cycle row_valid strobe. Raising wr_en
 * during the drain pauses it.
 */

module row_buffer (
  input  logic          clk,
  input  logic          resetn,
  input  logic          wr_en,
  input  aes_pkg::row_t in_row,
  output logic          full,
  output aes_pkg::row_t row_data,
  output logic          row_valid
);

  aes_pkg::buf_state_t state;
  aes_pkg::row_t       mem [aes_pkg::NUM_ROWS];
  aes_pkg::row_idx_t   wr_ptr;
  aes_pkg::row_idx_t   rd_ptr;
  logic                do_write;
  logic                do_read;

  // writes only land while filling, extra writes when full are dropped
  assign do_write = wr_en && (state == aes_pkg::FILLING);

  // drain condition, wr_en high holds the drain in place
  assign do_read = !wr_en && (state != aes_pkg::FILLING);

  assign full = (state != aes_pkg::FILLING);

  // row store and output register
  always_ff @(posedge clk)
  begin
    if (do_write)
    begin
      mem[wr_ptr] <= in_row;
    end
    if (do_read)
    begin
      row_data <= mem[rd_ptr];
    end
  end

  // pointers and fill/drain FSM
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state     <= aes_pkg::FILLING;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      row_valid <= 1'b0;
    end
    else
    begin
      row_valid <= do_read;
      case (state)
        aes_pkg::FILLING:
        begin
          if (do_write)
          begin
            if (wr_ptr == aes_pkg::row_idx_t'(aes_pkg::NUM_ROWS - 1))
            begin
              wr_ptr <= '0;
              state  <= aes_pkg::FULL;
            end
            else
            begin
              wr_ptr <= wr_ptr + 2'd1;
            end
          end
        end
        aes_pkg::FULL:
        begin
          // first release, row 0
          if (do_read)
          begin
            rd_ptr <= rd_ptr + 2'd1;
            state  <= aes_pkg::DRAINING;
          end
        end
        aes_pkg::DRAINING:
        begin
          if (do_read)
          begin
            if (rd_ptr == aes_pkg::row_idx_t'(aes_pkg::NUM_ROWS - 1))
            begin
              // last row out, buffer free again
              rd_ptr <= '0;
              state  <= aes_pkg::FILLING;
            end
            else
            begin
              rd_ptr <= rd_ptr + 2'd1;
            end
          end
        end
        default:
        begin
          state <= aes_pkg::FILLING;
        end
      endcase
    end
  end

endmodule

// ==== shift_rows/row_shifter.sv ====
/*
 * Row shifter
 * ShiftRows on one row per strobe. Row r of the state is rotated
 * left by r byte positions, so shifted byte j is input byte
 * (j + r) mod 4. The row index is kept locally and steps once per
 * row_valid. done goes low for one cycle with the new row on outp.
 */

module row_shifter (
  input  logic          clk,
  input  logic          resetn,
  input  aes_pkg::row_t row_in,
  input  logic          row_valid,
  output aes_pkg::row_t outp,
  output logic          done
);

  aes_pkg::row_idx_t row_cnt;

  // byte rotate left by amt positions
  function automatic aes_pkg::row_t rotate_row(input aes_pkg::row_t    r_in,
                                               input aes_pkg::row_idx_t amt);
    aes_pkg::row_t  r_out;
    aes_pkg::byte_t b;
    int unsigned    src;
    r_out = '0;
    for (int j = 0; j < aes_pkg::NUM_ROWS; j++)
    begin
      src = (j + int'(amt)) % aes_pkg::NUM_ROWS;
      b   = r_in[src*$bits(aes_pkg::byte_t) +: $bits(aes_pkg::byte_t)];
      r_out[j*$bits(aes_pkg::byte_t) +: $bits(aes_pkg::byte_t)] = b;
    end
    return r_out;
  endfunction

  // shifted row register, holds between strobes
  always_ff @(posedge clk)
  begin
    if (row_valid)
    begin
      outp <= rotate_row(row_in, row_cnt);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      row_cnt <= '0;
      done    <= 1'b1;
    end
    else
    begin
      // active low, one cycle per shifted row
      done <= !row_valid;
      if (row_valid)
      begin
        if (row_cnt == aes_pkg::row_idx_t'(aes_pkg::NUM_ROWS - 1))
        begin
          row_cnt <= '0;
        end
        else
        begin
          row_cnt <= row_cnt + 2'd1;
        end
      end
    end
  end

endmodule

// ==== hw/state_collector.sv ====
/*
 * State collector
 * Rebuilds the 16-byte state from the shifted rows. Each done-low
 * cycle writes outp into the next row slot. One cycle after the
 * fourth row lands, the assembled state is copied to state_out and
 * state_valid pulses for one cycle, leaving the assembly register
 * free for the next state straight away.
 */

module state_collector (
  input  logic            clk,
  input  logic            resetn,
  input  aes_pkg::row_t   outp,
  input  logic            done,
  output aes_pkg::state_t state_out,
  output logic            state_valid
);

  aes_pkg::state_t   asm_q;
  aes_pkg::row_idx_t slot;
  logic              complete;
  logic              last_slot;

  assign last_slot = (slot == aes_pkg::row_idx_t'(aes_pkg::NUM_ROWS - 1));

  // assembly register, row r at bit offset 32*r
  always_ff @(posedge clk)
  begin
    if (!done)
    begin
      asm_q[slot*$bits(aes_pkg::row_t) +: $bits(aes_pkg::row_t)] <= outp;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      slot        <= '0;
      complete    <= 1'b0;
      state_valid <= 1'b0;
      state_out   <= '0;
    end
    else
    begin
      // set on the edge that stores the fourth row
      complete    <= !done && last_slot;
      state_valid <= complete;

      if (complete)
      begin
        state_out <= asm_q;
      end

      if (!done)
      begin
        if (last_slot)
        begin
          slot <= '0;
        end
        else
        begin
          slot <= slot + 2'd1;
        end
      end
    end
  end

endmodule

// ==== hw/shift_rows_top.sv ====
/*
 * ShiftRows subsystem top
 * Streams an AES state in row by row, applies ShiftRows and returns
 * the full shifted state with a state_valid pulse. The path runs
 * through the row buffer, the row shifter and the state collector,
 * each holding a different row in flight.
 */

module shift_rows_top (
  input  logic            clk,
  input  logic            resetn,
  input  logic            wr_en,
  input  aes_pkg::row_t   in_row,
  output logic            full,
  output aes_pkg::state_t state_out,
  output logic            state_valid
);

  // buffer to shifter
  aes_pkg::row_t row_data;
  logic          row_valid;

  // shifter to collector
  aes_pkg::row_t shift_row;
  logic          shift_done;

  row_buffer u_row_buffer (
    .clk       (clk),
    .resetn    (resetn),
    .wr_en     (wr_en),
    .in_row    (in_row),
    .full      (full),
    .row_data  (row_data),
    .row_valid (row_valid)
  );

  row_shifter u_row_shifter (
    .clk       (clk),
    .resetn    (resetn),
    .row_in    (row_data),
    .row_valid (row_valid),
    .outp      (shift_row),
    .done      (shift_done)
  );

  state_collector u_state_collector (
    .clk         (clk),
    .resetn      (resetn),
    .outp        (shift_row),
    .done        (shift_done),
    .state_out   (state_out),
    .state_valid (state_valid)
  );

endmodule

// ==== verif/tb_shift_rows.sv ====
/*
 * ShiftRows subsystem testbench
 * Directed tests for the streaming ShiftRows path: reset values, a known
 * state, a run of LFSR states, writes while full and a paused drain.
 * Shifted states and state_valid timing are checked against a byte model.
 */

module tb_shift_rows;

  localparam int CLK_PERIOD    = 20;
  localparam int RANDOM_STATES = 20;
  localparam int RESULT_WAIT   = 40;
  // known state, random run, overfill state, two paused-drain states
  localparam int TOTAL_ROWS      = (RANDOM_STATES + 4) * aes_pkg::NUM_ROWS;
  localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 20 + 200;
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

  logic            clk = 1'b0;
  logic            resetn;
  logic            wr_en;
  aes_pkg::row_t   in_row;
  logic            full;
  aes_pkg::state_t state_out;
  logic            state_valid;

  int              cyc = 0;
  logic [31:0]     lfsr = 32'h8add;
  aes_pkg::state_t exp_states[$];
  aes_pkg::state_t got_states[$];
  int              exp_cycles[$];
  int              got_cycles[$];
  string           test_name;
  int              test_errors = 0;
  int              pass_count = 0;
  int              fail_count = 0;

  shift_rows_top UUT (
    .clk         (clk),
    .resetn      (resetn),
    .wr_en       (wr_en),
    .in_row      (in_row),
    .full        (full),
    .state_out   (state_out),
    .state_valid (state_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // capture every completed state with its edge number
  always @(negedge clk)
  begin
    if (resetn && state_valid)
    begin
      got_states.push_back(state_out);
      got_cycles.push_back(cyc);
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? LFSR_POLY : 32'h0);
  endfunction

  // one LFSR step per bit taken
  function automatic aes_pkg::row_t rand_row();
    aes_pkg::row_t r;
    r = '0;
    for (int i = 0; i < $bits(aes_pkg::row_t); i++)
    begin
      r[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  // byte j of row r takes input byte (j + r) mod 4
  function automatic aes_pkg::state_t shift_model(input aes_pkg::state_t s);
    aes_pkg::state_t o;
    int              src;
    o = '0;
    for (int r = 0; r < aes_pkg::NUM_ROWS; r++)
    begin
      for (int j = 0; j < aes_pkg::NUM_ROWS; j++)
      begin
        src = (j + r) % aes_pkg::NUM_ROWS;
        o[(r * aes_pkg::NUM_ROWS + j) * 8 +: 8] = s[(r * aes_pkg::NUM_ROWS + src) * 8 +: 8];
      end
    end
    return o;
  endfunction

  task automatic check_bit(input string what, input logic exp, input logic act);
    assert (act === exp)
    else
    begin
      $display("mismatch %s %s expected %0b actual %0b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  // writes one state, optional junk writes while full, optional pause mid-drain
  task automatic send_state(input aes_pkg::state_t s, input int extra, input int pause);
    int drain_edge;
    for (int r = 0; r < aes_pkg::NUM_ROWS; r++)
    begin
      @(posedge clk);
      wr_en  <= 1'b1;
      in_row <= s[r * 32 +: 32];
      @(negedge clk);
      check_bit("full before fourth write", 1'b0, full);
    end
    @(posedge clk);
    wr_en  <= (extra > 0);
    in_row <= rand_row();
    @(negedge clk);
    check_bit("full after fourth write", 1'b1, full);
    if (extra > 0)
    begin
      repeat (extra - 1)
      begin
        @(posedge clk);
        wr_en  <= 1'b1;
        in_row <= rand_row();
      end
      @(posedge clk);
      wr_en <= 1'b0;
      @(negedge clk);
    end
    drain_edge = cyc + 1;
    exp_states.push_back(shift_model(s));
    exp_cycles.push_back(drain_edge + 6 + pause);
    // rows 0 and 1 leave, then the pause
    @(posedge clk);
    @(posedge clk);
    repeat (pause)
    begin
      wr_en  <= 1'b1;
      in_row <= rand_row();
      @(posedge clk);
    end
    wr_en <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_bit("full after drain", 1'b0, full);
  endtask

  task automatic wait_results(input int n);
    int waited;
    waited = 0;
    while (got_states.size() < n && waited < RESULT_WAIT)
    begin
      @(posedge clk);
      waited++;
    end
    // quiet period to catch stray pulses
    repeat (8) @(posedge clk);
    assert (got_states.size() == n)
    else
    begin
      $display("%s: expected %0d state_valid pulses but saw %0d",
               test_name, n, got_states.size());
      test_errors++;
    end
  endtask

  task automatic compare_results();
    int n;
    n = (got_states.size() < exp_states.size()) ? got_states.size() : exp_states.size();
    for (int i = 0; i < n; i++)
    begin
      assert (got_states[i] === exp_states[i])
      else
      begin
        $display("mismatch %s state %0d expected %h actual %h",
                 test_name, i, exp_states[i], got_states[i]);
        test_errors++;
      end
      assert (got_cycles[i] == exp_cycles[i])
      else
      begin
        $display("mismatch %s state %0d valid cycle expected %0d actual %0d",
                 test_name, i, exp_cycles[i], got_cycles[i]);
        test_errors++;
      end
    end
    exp_states.delete();
    got_states.delete();
    exp_cycles.delete();
    got_cycles.delete();
  endtask

  task automatic report_test();
    if (test_errors == 0)
    begin
      pass_count++;
      $display("%s: pass", test_name);
    end
    else
    begin
      fail_count++;
      $display("%s: fail, %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic check_reset();
    test_name = "reset_state";
    @(negedge clk);
    check_bit("full", 1'b0, full);
    check_bit("state_valid", 1'b0, state_valid);
    assert (state_out === '0)
    else
    begin
      $display("mismatch %s state_out expected 0 actual %h", test_name, state_out);
      test_errors++;
    end
    report_test();
  endtask

  task automatic rotate_known_state();
    aes_pkg::state_t s;
    test_name = "single_state";
    for (int b = 0; b < 16; b++)
    begin
      s[b * 8 +: 8] = 8'(16 * (b / 4) + (b % 4) + 1);
    end
    send_state(s, 0, 0);
    wait_results(1);
    compare_results();
    report_test();
  endtask

  task automatic stream_random_states();
    aes_pkg::state_t s;
    test_name = "random_states";
    for (int k = 0; k < RANDOM_STATES; k++)
    begin
      for (int r = 0; r < aes_pkg::NUM_ROWS; r++)
      begin
        s[r * 32 +: 32] = rand_row();
      end
      send_state(s, 0, 0);
    end
    wait_results(RANDOM_STATES);
    compare_results();
    report_test();
  endtask

  // junk rows written while full must be dropped
  task automatic overfill_buffer();
    aes_pkg::state_t s;
    test_name = "full_behavior";
    s = {32'h0f0e0d0c, 32'hb3b2b1b0, 32'h77665544, 32'hdeadbeef};
    send_state(s, 3, 0);
    wait_results(1);
    compare_results();
    report_test();
  endtask

  // second state confirms the row counters are still aligned
  task automatic pause_drain();
    aes_pkg::state_t s;
    test_name = "paused_drain";
    s = {32'h33323130, 32'h23222120, 32'h13121110, 32'h03020100};
    send_state(s, 0, 3);
    s = {32'hf3f2f1f0, 32'he3e2e1e0, 32'hd3d2d1d0, 32'hc3c2c1c0};
    send_state(s, 0, 0);
    wait_results(2);
    compare_results();
    report_test();
  endtask

  initial
  begin
    resetn <= 1'b0;
    wr_en  <= 1'b0;
    in_row <= '0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    check_reset();
    rotate_known_state();
    stream_random_states();
    overfill_buffer();
    pause_drain();
    $display("summary: %0d tests ok, %0d tests bad", pass_count, fail_count);
    if (fail_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
common/aes_pkg.sv
shift_rows/row_buffer.sv
shift_rows/row_shifter.sv
hw/state_collector.sv
hw/shift_rows_top.sv
verif/tb_shift_rows.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the ShiftRows testbench with Verilator, run it and check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_shift_rows -f verilog.f \
  && out="$(./obj_dir/Vtb_shift_rows)" \
  && echo "$out" \
  && echo "$out" | grep -qx "test passed" \
  && echo "simulation PASS" && exit 0 \
  || { echo "simulation FAIL"; exit 1; }
